//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_uart_cmd
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+.
uart_pkg.sv
uart_link_if.sv
uart_tx_frame.sv
uart_rx_frame.sv
uart_cmd_ctrl.sv
uart_cmd_top.sv
tb_uart_cmd_sva.sv
tb_uart_cmd.sv

//--- tb_uart_cmd.sv
`timescale 1ns/10ps
`include "uart_defs.svh"

module tb_uart_cmd
  import uart_pkg::*;
();

  localparam int CPB       = `UART_CLKS_PER_BIT;
  localparam int HALF_BIT  = `UART_SAMPLE_POINT;
  localparam int BUSY_WAIT = 4 * 11 * CPB + `UART_TURNAROUND + `UART_REPLY_TIMEOUT;
  localparam int IDLE_WAIT = 20 * BUSY_WAIT;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        rx;
  logic        tx;
  logic        read_vld;
  logic [7:0]  read_data;
  logic        read_err;

  int unsigned err_cnt;
  int unsigned timeout_cnt;
  logic [31:0] lcg_state;
  logic [7:0]  dev_regs [128];
  logic [7:0]  shadow [128];
  bit          dev_silent;
  bit          dev_flip_par;

  uart_cmd_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_err  (read_err)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Power-up contents of the device registers
  function automatic logic [7:0] fill_value(input logic [6:0] a);
    return {a, ~a[0]} ^ 8'h3c;
  endfunction

  //////////////////////////////
  // Serial device model
  //////////////////////////////

  task automatic recv_frame(output logic [7:0] b, output bit got);
    int unsigned n;
    logic        par;
    got = 1'b0;
    b   = 8'h00;
    n   = 0;
    while (tx !== 1'b0 && n < IDLE_WAIT)
    begin
      @(negedge clk);
      n++;
    end
    if (tx !== 1'b0)
    begin
      timeout_cnt++;
      $display("Timeout: device model waited too long for a start bit on tx");
      return;
    end
    repeat (HALF_BIT) @(negedge clk);
    assert (tx == 1'b0)
    else begin
      err_cnt++;
      $display("** Error @ %0t: start bit not low at mid-bit", $time);
    end
    // LSB first
    for (int i = 0; i < 8; i++)
    begin
      repeat (CPB) @(negedge clk);
      b[i] = tx;
    end
    repeat (CPB) @(negedge clk);
    par = tx;
    assert (par == ~^b)
    else begin
      err_cnt++;
      $display("** Error @ %0t: parity %0b for data %02h, expected %0b", $time, par, b, ~^b);
    end
    repeat (CPB) @(negedge clk);
    assert (tx == 1'b1)
    else begin
      err_cnt++;
      $display("** Error @ %0t: stop bit low after data %02h", $time, b);
    end
    got = 1'b1;
  endtask

  task automatic send_frame(input logic [7:0] b, input bit flip);
    logic [10:0] bits;
    bits = {1'b1, (~^b) ^ flip, b, 1'b0};
    #1;
    for (int i = 0; i < 11; i++)
    begin
      rx = bits[i];
      repeat (CPB) @(posedge clk);
      #1;
    end
  endtask

  initial
  begin : device_model
    uart_cmd_u  dev_cmd;
    logic [7:0] b;
    bit         got;
    for (int i = 0; i < 128; i++)
      dev_regs[i] = fill_value(7'(i));
    // Past the reset window
    repeat (6) @(posedge clk);
    while (1)
    begin
      recv_frame(b, got);
      if (!got)
        break;
      dev_cmd.bytes.hi = b;
      if (dev_cmd.fields.rw)
      begin
        recv_frame(b, got);
        if (!got)
          break;
        dev_cmd.bytes.lo = b;
        dev_regs[dev_cmd.fields.addr] = dev_cmd.fields.wdata;
      end
      else if (!dev_silent)
      begin
        repeat (2 * CPB) @(posedge clk);
        send_frame(dev_regs[dev_cmd.fields.addr], dev_flip_par);
      end
    end
  end

  //////////////////////////////
  // Command driver
  //////////////////////////////

  task automatic issue_cmd(input logic [15:0] c, input bit keep_vld);
    int unsigned n;
    cmd_in  = c;
    cmd_vld = 1'b1;
    n = 0;
    while (!cmd_rdy && n < BUSY_WAIT)
    begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!cmd_rdy)
    begin
      timeout_cnt++;
      cmd_vld = 1'b0;
      $display("Timeout: cmd_rdy stayed low while a command was pending");
      return;
    end
    // Handshake edge
    @(posedge clk);
    #1;
    if (!keep_vld)
      cmd_vld = 1'b0;
  endtask

  task automatic do_write(input logic [6:0] a, input logic [7:0] d, input bit keep_vld);
    uart_cmd_u c;
    c.fields.rw    = 1'b1;
    c.fields.addr  = a;
    c.fields.wdata = d;
    shadow[a] = d;
    issue_cmd(c, keep_vld);
  endtask

  task automatic do_read(input logic [6:0] a, input bit exp_err, input bit exp_zero);
    uart_cmd_u   c;
    int unsigned n;
    c.fields.rw    = 1'b0;
    c.fields.addr  = a;
    c.fields.wdata = 8'h00;
    issue_cmd(c, 1'b0);
    if (timeout_cnt != 0)
      return;
    n = 0;
    while (!read_vld && n < BUSY_WAIT)
    begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!read_vld)
    begin
      timeout_cnt++;
      $display("Timeout: no read_vld after a read of address %02h", a);
      return;
    end
    assert (read_err == exp_err)
    else begin
      err_cnt++;
      $display("** Error @ %0t: read_err %0b, expected %0b", $time, read_err, exp_err);
    end
    if (exp_zero)
    begin
      assert (read_data == 8'h00)
      else begin
        err_cnt++;
        $display("** Error @ %0t: read_data %02h after timeout, expected 00", $time, read_data);
      end
    end
    else if (!exp_err)
    begin
      assert (read_data == shadow[a] && dev_regs[a] == shadow[a])
      else begin
        err_cnt++;
        $display("** Error @ %0t: read_data %02h, device %02h, expected %02h at %02h",
                 $time, read_data, dev_regs[a], shadow[a], a);
      end
    end
  endtask

  task automatic run_tests();
    logic [31:0] r;
    // Write then read back
    for (int i = 0; i < 6; i++)
    begin
      r = next_rand();
      do_write(r[14:8], r[7:0], 1'b0);
      do_read(r[14:8], 1'b0, 1'b0);
      if (timeout_cnt != 0)
        return;
    end
    // Random mix
    for (int i = 0; i < 6; i++)
    begin
      r = next_rand();
      if (r[31])
        do_write(r[22:16], r[7:0], 1'b0);
      else
        do_read(r[22:16], 1'b0, 1'b0);
      if (timeout_cnt != 0)
        return;
    end
    r = next_rand();
    dev_flip_par = 1'b1;
    do_read(r[14:8], 1'b1, 1'b0);
    dev_flip_par = 1'b0;
    if (timeout_cnt != 0)
      return;
    dev_silent = 1'b1;
    do_read(r[14:8], 1'b1, 1'b1);
    dev_silent = 1'b0;
    if (timeout_cnt != 0)
      return;
    // Read held on cmd_vld while the write is busy
    r = next_rand();
    do_write(r[14:8], r[7:0], 1'b1);
    do_read(r[14:8], 1'b0, 1'b0);
  endtask

  task automatic end_run();
    int unsigned sva_fails;
    sva_fails = u_dut.u_sva.fail_cnt;
    $display("Errors: %0d value, %0d timeout, %0d assertion",
             err_cnt, timeout_cnt, sva_fails);
    if (err_cnt == 0 && timeout_cnt == 0 && sva_fails == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  endtask

  initial
  begin
    rst_n        = 1'b1;
    cmd_in       = 16'h0000;
    cmd_vld      = 1'b0;
    rx           = 1'b1;
    err_cnt      = 0;
    timeout_cnt  = 0;
    lcg_state    = 32'hf459;
    dev_silent   = 1'b0;
    dev_flip_par = 1'b0;
    for (int i = 0; i < 128; i++)
      shadow[i] = fill_value(7'(i));
    #1 rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    run_tests();
    end_run();
  end

endmodule

//--- tb_uart_cmd_sva.sv
`timescale 1ns/10ps
`include "uart_defs.svh"

module tb_uart_cmd_sva (
  input logic        clk,
  input logic        rst_n,
  input logic [15:0] cmd_in,
  input logic        cmd_vld,
  input logic        cmd_rdy,
  input logic        tx,
  input logic        read_vld
);

  localparam int CPB       = `UART_CLKS_PER_BIT;
  localparam int FRAME_LEN = 11 * CPB;

  int unsigned fail_cnt = 0;
  logic        tx_q;
  int unsigned run_len;
  int unsigned frame_left;
  int unsigned frames_seen;
  int unsigned frames_owed;
  logic        rd_pending;

  // Line run length, frame starts and owed frames
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_q        <= 1'b1;
      run_len     <= CPB;
      frame_left  <= 0;
      frames_seen <= 0;
      frames_owed <= 0;
      rd_pending  <= 1'b0;
    end
    else
    begin
      tx_q <= tx;
      if (tx != tx_q)
        run_len <= 1;
      else if (run_len < CPB)
        run_len <= run_len + 1;
      if (frame_left != 0)
        frame_left <= frame_left - 1;
      else if (tx_q && !tx)
      begin
        frame_left  <= FRAME_LEN - 1;
        frames_seen <= frames_seen + 1;
      end
      if (cmd_vld && cmd_rdy)
      begin
        frames_owed <= frames_owed + (cmd_in[15] ? 2 : 1);
        rd_pending  <= !cmd_in[15];
      end
      else if (read_vld)
        rd_pending <= 1'b0;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_reset_idle: assert property (@(posedge clk) !rst_n |-> tx && cmd_rdy && !read_vld)
    else begin fail_cnt++; $error("outputs not idle during reset"); end

  a_bit_period: assert property (@(posedge clk) disable iff (!rst_n)
    (tx != tx_q) |-> (run_len >= CPB))
    else begin fail_cnt++; $error("tx level held for %0d cycles", run_len); end

  a_rdy_low_read: assert property (@(posedge clk) disable iff (!rst_n)
    rd_pending |-> !cmd_rdy)
    else begin fail_cnt++; $error("cmd_rdy high before read_vld"); end

  a_read_owned: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> rd_pending)
    else begin fail_cnt++; $error("read_vld without a pending read"); end

  // One address frame, plus a data frame for a write, per accepted command
  a_frames_match: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> (frames_seen == frames_owed))
    else begin fail_cnt++; $error("%0d frames sent, %0d owed", frames_seen, frames_owed); end

  a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
    frames_seen <= frames_owed)
    else begin fail_cnt++; $error("frame sent without a command"); end

endmodule

bind uart_cmd_top tb_uart_cmd_sva u_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_in   (cmd_in),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_vld (read_vld)
);

//--- uart_cmd_ctrl.sv
`timescale 1ns/10ps
`include "uart_defs.svh"

module uart_cmd_ctrl
  import uart_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  uart_cmd_u        cmd_in,
  input  logic             cmd_vld,
  output logic             cmd_rdy,
  output logic             read_vld,
  output logic [7:0]       read_data,
  output logic             read_err,
  uart_link_if.ctrl        link
);

  localparam int TURN_W = $clog2(`UART_TURNAROUND);
  localparam int TO_W   = $clog2(`UART_REPLY_TIMEOUT);
  localparam logic [TURN_W-1:0] TURN_LAST = TURN_W'(`UART_TURNAROUND - 1);
  localparam logic [TO_W-1:0]   TO_LAST   = TO_W'(`UART_REPLY_TIMEOUT - 1);

  localparam logic [2:0] S_IDLE      = 3'd0;
  localparam logic [2:0] S_SEND_ADDR = 3'd1;
  localparam logic [2:0] S_WAIT_CRED = 3'd2;
  localparam logic [2:0] S_TURN      = 3'd3;
  localparam logic [2:0] S_SEND_DATA = 3'd4;
  localparam logic [2:0] S_AWAIT     = 3'd5;
  localparam logic [2:0] S_DELIVER   = 3'd6;

  logic [2:0]        state;
  logic [1:0]        credits;
  logic              data_phase;
  logic [TURN_W-1:0] turn_cnt;
  logic [TO_W-1:0]   to_cnt;
  uart_cmd_u         cmd_q;
  logic              send;
  logic              timeout;

  assign cmd_rdy  = (state == S_IDLE);
  assign read_vld = (state == S_DELIVER);

  // Only send while a credit is held
  assign send = ((state == S_SEND_ADDR) || (state == S_SEND_DATA)) && (credits != 2'd0);
  assign link.tx_vld  = send;
  assign link.tx_data = (state == S_SEND_DATA) ? cmd_q.bytes.lo : cmd_q.bytes.hi;

  // Counter pauses once a start bit is seen
  assign timeout = (state == S_AWAIT) && !link.rx_vld && !link.rx_busy && (to_cnt == TO_LAST);

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= S_IDLE;
      credits    <= 2'd1;
      data_phase <= 1'b0;
      turn_cnt   <= '0;
      to_cnt     <= '0;
    end
    else
    begin
      credits <= credits + {1'b0, link.tx_credit} - {1'b0, send};
      case (state)
        S_IDLE:
          if (cmd_vld)
          begin
            state      <= S_SEND_ADDR;
            data_phase <= 1'b0;
          end
        S_SEND_ADDR:
          if (send)
            state <= S_WAIT_CRED;
        S_WAIT_CRED:
          if (link.tx_credit)
          begin
            if (!cmd_q.fields.rw)
            begin
              state  <= S_AWAIT;
              to_cnt <= '0;
            end
            else if (data_phase)
              state <= S_IDLE;
            else
            begin
              state    <= S_TURN;
              turn_cnt <= '0;
            end
          end
        S_TURN:
          if (turn_cnt == TURN_LAST)
            state <= S_SEND_DATA;
          else
            turn_cnt <= turn_cnt + 1'b1;
        S_SEND_DATA:
          if (send)
          begin
            state      <= S_WAIT_CRED;
            data_phase <= 1'b1;
          end
        S_AWAIT:
          if (link.rx_vld || timeout)
            state <= S_DELIVER;
          else if (!link.rx_busy)
            to_cnt <= to_cnt + 1'b1;
        S_DELIVER:
          state <= S_IDLE;
        default:
          state <= S_IDLE;
      endcase
    end
  end

  // Stored command and reply, frames outside S_AWAIT are dropped
  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
      cmd_q <= cmd_in;
    if (state == S_AWAIT && link.rx_vld)
    begin
      read_data <= link.rx_data;
      read_err  <= link.rx_err;
    end
    else if (timeout)
    begin
      read_data <= 8'h00;
      read_err  <= 1'b1;
    end
  end

endmodule

//--- uart_cmd_top.sv
`timescale 1ns/10ps

module uart_cmd_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] cmd_in,
  input  logic        cmd_vld,
  output logic        cmd_rdy,
  input  logic        rx,
  output logic        tx,
  output logic        read_vld,
  output logic [7:0]  read_data,
  output logic        read_err
);

  uart_link_if link ();

  // Command sequencer
  uart_cmd_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_err  (read_err),
    .link      (link.ctrl)
  );

  // Serial framers
  uart_tx_frame u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .link  (link.tx),
    .tx    (tx)
  );

  uart_rx_frame u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .link  (link.rx)
  );

endmodule

//--- uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

//////////////////////////////
// Serial timing
//////////////////////////////

// Clocks per serial bit, 434 for 115200 baud at 50 MHz
`define UART_CLKS_PER_BIT 16

// Mid-bit sample offset
`define UART_SAMPLE_POINT (`UART_CLKS_PER_BIT / 2)

// Idle gap between address and data frames of a write
`define UART_TURNAROUND 100

// Wait for a reply start bit, 40 bit periods
`define UART_REPLY_TIMEOUT (40 * `UART_CLKS_PER_BIT)

`endif

//--- uart_link_if.sv
`timescale 1ns/10ps

interface uart_link_if;

  // Transmit side, credit based
  logic       tx_vld;
  logic [7:0] tx_data;
  logic       tx_credit;

  // Receive side, no flow control
  logic       rx_vld;
  logic [7:0] rx_data;
  logic       rx_err;
  logic       rx_busy;

  modport ctrl (
    output tx_vld,
    output tx_data,
    input  tx_credit,
    input  rx_vld,
    input  rx_data,
    input  rx_err,
    input  rx_busy
  );

  modport tx (
    input  tx_vld,
    input  tx_data,
    output tx_credit
  );

  modport rx (
    output rx_vld,
    output rx_data,
    output rx_err,
    output rx_busy
  );

endinterface

//--- uart_pkg.sv
package uart_pkg;

  //////////////////////////////
  // Command word
  //////////////////////////////

  // Byte view for the serializer, field view for the sequencer
  typedef union packed {
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } bytes;
    struct packed {
      logic       rw;
      logic [6:0] addr;
      logic [7:0] wdata;
    } fields;
  } uart_cmd_u;

endpackage

//--- uart_rx_frame.sv
`timescale 1ns/10ps
`include "uart_defs.svh"

module uart_rx_frame (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    rx,
  uart_link_if.rx link
);

  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UART_CLKS_PER_BIT - 1);
  // Edge is seen one cycle into the start bit
  localparam logic [CNT_W-1:0] START_CHK = CNT_W'(`UART_SAMPLE_POINT - 1);

  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_START = 3'd1;
  localparam logic [2:0] ST_DATA  = 3'd2;
  localparam logic [2:0] ST_PAR   = 3'd3;
  localparam logic [2:0] ST_STOP  = 3'd4;

  logic [1:0]       sync_q;
  logic             rx_s;
  logic             rx_prev;
  logic             fall;
  logic [2:0]       state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       data_idx;
  logic [7:0]       shreg;
  logic             par_q;
  logic             sample;

  assign rx_s   = sync_q[1];
  assign fall   = rx_prev && !rx_s;
  assign sample = (cnt == BIT_LAST);

  assign link.rx_busy = (state != ST_IDLE);

  //////////////////////////////
  // Sync and frame FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_q      <= 2'b11;
      rx_prev     <= 1'b1;
      state       <= ST_IDLE;
      cnt         <= '0;
      data_idx    <= '0;
      link.rx_vld <= 1'b0;
    end
    else
    begin
      sync_q      <= {sync_q[0], rx};
      rx_prev     <= rx_s;
      link.rx_vld <= 1'b0;
      case (state)
        ST_IDLE:
          if (fall)
          begin
            state <= ST_START;
            cnt   <= '0;
          end
        ST_START:
          if (cnt == START_CHK)
          begin
            cnt      <= '0;
            data_idx <= '0;
            // Glitch, line already back high
            state    <= rx_s ? ST_IDLE : ST_DATA;
          end
          else
            cnt <= cnt + 1'b1;
        ST_DATA:
          if (sample)
          begin
            cnt      <= '0;
            data_idx <= data_idx + 3'd1;
            if (data_idx == 3'd7)
              state <= ST_PAR;
          end
          else
            cnt <= cnt + 1'b1;
        ST_PAR:
          if (sample)
          begin
            cnt   <= '0;
            state <= ST_STOP;
          end
          else
            cnt <= cnt + 1'b1;
        ST_STOP:
          if (sample)
          begin
            cnt         <= '0;
            state       <= ST_IDLE;
            link.rx_vld <= 1'b1;
          end
          else
            cnt <= cnt + 1'b1;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Received bits and result
  always_ff @(posedge clk)
  begin
    if (state == ST_DATA && sample)
      shreg <= {rx_s, shreg[7:1]};
    if (state == ST_PAR && sample)
      par_q <= rx_s;
    if (state == ST_STOP && sample)
    begin
      link.rx_data <= shreg;
      link.rx_err  <= (par_q != ~^shreg) || !rx_s;
    end
  end

endmodule

//--- uart_tx_frame.sv
`timescale 1ns/10ps
`include "uart_defs.svh"

module uart_tx_frame (
  input  logic    clk,
  input  logic    rst_n,
  uart_link_if.tx link,
  output logic    tx
);

  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);

  // Bit index of the frame: 0 start, 1..8 data, 9 parity, 10 stop
  localparam logic [3:0] IDX_PAR  = 4'd9;
  localparam logic [3:0] IDX_STOP = 4'd10;

  logic             busy;
  logic [CNT_W-1:0] bit_cnt;
  logic [3:0]       bit_idx;
  logic [7:0]       hold_q;
  logic             par_q;
  logic             bit_end;
  logic [3:0]       next_idx;

  assign bit_end  = busy && (bit_cnt == BIT_LAST);
  assign next_idx = bit_idx + 4'd1;

  // Credit goes back in the last cycle of the stop bit
  assign link.tx_credit = bit_end && (bit_idx == IDX_STOP);

  //////////////////////////////
  // Bit timing and line
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end
    else if (!busy)
    begin
      if (link.tx_vld)
      begin
        busy    <= 1'b1;
        bit_cnt <= '0;
        bit_idx <= '0;
        tx      <= 1'b0;
      end
    end
    else if (bit_end)
    begin
      bit_cnt <= '0;
      if (bit_idx == IDX_STOP)
      begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end
      else
      begin
        bit_idx <= next_idx;
        if (next_idx < IDX_PAR)
          tx <= hold_q[0];
        else if (next_idx == IDX_PAR)
          tx <= par_q;
        else
          tx <= 1'b1;
      end
    end
    else
      bit_cnt <= bit_cnt + 1'b1;
  end

  // Holding slot, shifted out LSB first
  always_ff @(posedge clk)
  begin
    if (!busy && link.tx_vld)
    begin
      hold_q <= link.tx_data;
      par_q  <= ~^link.tx_data;
    end
    else if (bit_end && next_idx < IDX_PAR)
      hold_q <= {1'b0, hold_q[7:1]};
  end

endmodule
